/* common/aplic_pkg.sv */
// APLIC domain register control package
// Sizes, register offsets, register kinds and the packed
// views of the sourcecfg and target words

package aplic_pkg;

  // ============================================================
  // Sizes and domains
  // ============================================================
  localparam int NR_SRC = 32;
  localparam int SRC_W  = 5;
  localparam int ADDR_W = 14;

  localparam logic DOMAIN_M = 1'b0;
  localparam logic DOMAIN_S = 1'b1;

  // ============================================================
  // Register offsets inside one domain
  // ============================================================
  localparam logic [ADDR_W-1:0] OFF_DOMAINCFG = 14'h0000;
  localparam logic [ADDR_W-1:0] OFF_SOURCECFG = 14'h0004;
  localparam logic [ADDR_W-1:0] OFF_SETIP     = 14'h1C00;
  localparam logic [ADDR_W-1:0] OFF_SETIPNUM  = 14'h1CDC;
  localparam logic [ADDR_W-1:0] OFF_IN_CLRIP  = 14'h1D00;
  localparam logic [ADDR_W-1:0] OFF_CLRIPNUM  = 14'h1DDC;
  localparam logic [ADDR_W-1:0] OFF_SETIE     = 14'h1E00;
  localparam logic [ADDR_W-1:0] OFF_SETIENUM  = 14'h1EDC;
  localparam logic [ADDR_W-1:0] OFF_CLRIE     = 14'h1F00;
  localparam logic [ADDR_W-1:0] OFF_CLRIENUM  = 14'h1FDC;
  localparam logic [ADDR_W-1:0] OFF_TARGET    = 14'h3004;

  // Read value of domaincfg always carries bit 31
  localparam logic [31:0] DOMAINCFG_FIXED = 32'h8000_0000;

  typedef enum logic [3:0] {
    KIND_NONE,
    KIND_DOMAINCFG,
    KIND_SOURCECFG,
    KIND_SETIP,
    KIND_CLRIP,
    KIND_SETIPNUM,
    KIND_CLRIPNUM,
    KIND_SETIE,
    KIND_CLRIE,
    KIND_SETIENUM,
    KIND_CLRIENUM,
    KIND_TARGET
  } reg_kind_e;

  // Source modes
  localparam logic [2:0] SM_INACTIVE = 3'd0;
  localparam logic [2:0] SM_DETACHED = 3'd1;
  localparam logic [2:0] SM_EDGE1    = 3'd4;
  localparam logic [2:0] SM_EDGE0    = 3'd5;
  localparam logic [2:0] SM_LEVEL1   = 3'd6;
  localparam logic [2:0] SM_LEVEL0   = 3'd7;

  // sourcecfg seen as a delegation or as a source mode
  typedef union packed {
    struct packed {logic d; logic [9:0] child;} deleg;
    struct packed {logic d; logic [6:0] rsvd; logic [2:0] sm;} mode;
  } sourcecfg_u;

  // target in direct delivery or in MSI delivery
  typedef union packed {
    struct packed {logic [13:0] hart; logic [9:0] zero; logic [7:0] prio;} direct;
    struct packed {logic [13:0] hart; logic [5:0] guest; logic rsvd; logic [10:0] eiid;} msi;
  } target_u;

endpackage

/* common/aplic_reg_if.sv */
// Decoded register write
// One write per cycle from the decoder to the register blocks,
// taken in the cycle that wr_valid is high

`timescale 1ns/1ps

interface reg_wr_if;

  logic                          wr_valid;
  logic                          wr_domain;
  aplic_pkg::reg_kind_e          wr_kind;
  logic [aplic_pkg::SRC_W-1:0]   wr_index;
  logic [31:0]                   wr_data;

  modport decoder (
    output wr_valid, wr_domain, wr_kind, wr_index, wr_data
  );

  modport sink (
    input wr_valid, wr_domain, wr_kind, wr_index, wr_data
  );

endinterface

/* design/aplic_domain_top.sv */
// APLIC domain register control, top level
// Two domains (M and S) sharing 31 sources; connects the
// register decoder to the config, pending/enable and target blocks

`timescale 1ns/1ps

module aplic_domain_top (
  input  logic                           i_clk,
  input  logic                           ni_rst,
  // Write port
  input  logic                           i_wr_valid,
  input  logic                           i_wr_domain,
  input  logic [aplic_pkg::ADDR_W-1:0]   i_wr_addr,
  input  logic [31:0]                    i_wr_data,
  // Read port
  input  logic                           i_rd_valid,
  input  logic                           i_rd_domain,
  input  logic [aplic_pkg::ADDR_W-1:0]   i_rd_addr,
  output logic                           o_rd_valid,
  output logic [31:0]                    o_rd_data,
  // Sources and state
  input  logic [aplic_pkg::NR_SRC-1:0]   i_src_set,
  output logic [aplic_pkg::NR_SRC-1:0]   o_active,
  output logic [aplic_pkg::NR_SRC-1:0]   o_pending,
  output logic [aplic_pkg::NR_SRC-1:0]   o_enable,
  output logic [aplic_pkg::NR_SRC-1:0]   o_intp_domain,
  output logic [1:0]                     o_domain_ie,
  output logic [1:0]                     o_domain_dm
);

  logic [1:0]                                       domain_be;
  aplic_pkg::sourcecfg_u [aplic_pkg::NR_SRC-1:1]    sourcecfg;
  logic [aplic_pkg::NR_SRC-1:1][31:0]               target;

  reg_wr_if wr_bus ();

  aplic_reg_decode u_decode (
    .i_clk         (i_clk),
    .ni_rst        (ni_rst),
    .i_wr_valid    (i_wr_valid),
    .i_wr_domain   (i_wr_domain),
    .i_wr_addr     (i_wr_addr),
    .i_wr_data     (i_wr_data),
    .i_rd_valid    (i_rd_valid),
    .i_rd_domain   (i_rd_domain),
    .i_rd_addr     (i_rd_addr),
    .i_domain_ie   (o_domain_ie),
    .i_domain_dm   (o_domain_dm),
    .i_domain_be   (domain_be),
    .i_sourcecfg   (sourcecfg),
    .i_intp_domain (o_intp_domain),
    .i_pending     (o_pending),
    .i_enable      (o_enable),
    .i_target      (target),
    .o_rd_valid    (o_rd_valid),
    .o_rd_data     (o_rd_data),
    .wr            (wr_bus)
  );

  aplic_source_cfg u_source_cfg (
    .i_clk         (i_clk),
    .ni_rst        (ni_rst),
    .o_domain_ie   (o_domain_ie),
    .o_domain_dm   (o_domain_dm),
    .o_domain_be   (domain_be),
    .o_sourcecfg   (sourcecfg),
    .o_intp_domain (o_intp_domain),
    .o_active      (o_active),
    .wr            (wr_bus)
  );

  aplic_pending_enable u_pending_enable (
    .i_clk         (i_clk),
    .ni_rst        (ni_rst),
    .i_src_set     (i_src_set),
    .i_active      (o_active),
    .i_intp_domain (o_intp_domain),
    .o_pending     (o_pending),
    .o_enable      (o_enable),
    .wr            (wr_bus)
  );

  aplic_target u_target (
    .i_clk         (i_clk),
    .ni_rst        (ni_rst),
    .i_active      (o_active),
    .i_intp_domain (o_intp_domain),
    .i_domain_dm   (o_domain_dm),
    .o_target      (target),
    .wr            (wr_bus)
  );

endmodule

/* design/aplic_reg_decode.sv */
// APLIC register decoder
// Maps write offsets to a register kind and source index, and
// builds each domain's read view with a one-cycle read register

`timescale 1ns/1ps

module aplic_reg_decode (
  input  logic                                      i_clk,
  input  logic                                      ni_rst,
  input  logic                                      i_wr_valid,
  input  logic                                      i_wr_domain,
  input  logic [aplic_pkg::ADDR_W-1:0]              i_wr_addr,
  input  logic [31:0]                               i_wr_data,
  input  logic                                      i_rd_valid,
  input  logic                                      i_rd_domain,
  input  logic [aplic_pkg::ADDR_W-1:0]              i_rd_addr,
  input  logic [1:0]                                i_domain_ie,
  input  logic [1:0]                                i_domain_dm,
  input  logic [1:0]                                i_domain_be,
  input  aplic_pkg::sourcecfg_u [aplic_pkg::NR_SRC-1:1] i_sourcecfg,
  input  logic [aplic_pkg::NR_SRC-1:0]              i_intp_domain,
  input  logic [aplic_pkg::NR_SRC-1:0]              i_pending,
  input  logic [aplic_pkg::NR_SRC-1:0]              i_enable,
  input  logic [aplic_pkg::NR_SRC-1:1][31:0]        i_target,
  output logic                                      o_rd_valid,
  output logic [31:0]                               o_rd_data,
  reg_wr_if.decoder                                 wr
);

  aplic_pkg::reg_kind_e              wr_kind;
  aplic_pkg::reg_kind_e              rd_kind;
  logic [aplic_pkg::SRC_W-1:0]       rd_idx;
  logic [aplic_pkg::NR_SRC-1:0]      own_mask;
  logic [31:0]                       rd_word;
  logic                              rd_valid_q;
  logic [31:0]                       rd_data_q;

  // Sourcecfg and target arrays are word-indexed from source 1
  function automatic aplic_pkg::reg_kind_e map_kind(input logic [aplic_pkg::ADDR_W-1:0] addr);
    aplic_pkg::reg_kind_e kind;
    kind = aplic_pkg::KIND_NONE;
    if (addr == aplic_pkg::OFF_DOMAINCFG) kind = aplic_pkg::KIND_DOMAINCFG;
    else if (addr == aplic_pkg::OFF_SETIP) kind = aplic_pkg::KIND_SETIP;
    else if (addr == aplic_pkg::OFF_SETIPNUM) kind = aplic_pkg::KIND_SETIPNUM;
    else if (addr == aplic_pkg::OFF_IN_CLRIP) kind = aplic_pkg::KIND_CLRIP;
    else if (addr == aplic_pkg::OFF_CLRIPNUM) kind = aplic_pkg::KIND_CLRIPNUM;
    else if (addr == aplic_pkg::OFF_SETIE) kind = aplic_pkg::KIND_SETIE;
    else if (addr == aplic_pkg::OFF_SETIENUM) kind = aplic_pkg::KIND_SETIENUM;
    else if (addr == aplic_pkg::OFF_CLRIE) kind = aplic_pkg::KIND_CLRIE;
    else if (addr == aplic_pkg::OFF_CLRIENUM) kind = aplic_pkg::KIND_CLRIENUM;
    else if (addr[1:0] == 2'b00 && addr[6:2] != '0) begin
      if (addr[13:7] == aplic_pkg::OFF_SOURCECFG[13:7]) kind = aplic_pkg::KIND_SOURCECFG;
      else if (addr[13:7] == aplic_pkg::OFF_TARGET[13:7]) kind = aplic_pkg::KIND_TARGET;
    end
    return kind;
  endfunction

  // ==========================================================
  // Write decode
  // ==========================================================
  assign wr_kind      = map_kind(i_wr_addr);
  assign wr.wr_valid  = i_wr_valid && (wr_kind != aplic_pkg::KIND_NONE);
  assign wr.wr_domain = i_wr_domain;
  assign wr.wr_kind   = wr_kind;
  assign wr.wr_index  = i_wr_addr[6:2];
  assign wr.wr_data   = i_wr_data;

  // ==========================================================
  // Read view of the selected domain
  // ==========================================================
  assign rd_kind  = map_kind(i_rd_addr);
  assign rd_idx   = i_rd_addr[6:2];
  assign own_mask = (i_rd_domain ? i_intp_domain : ~i_intp_domain) & ~32'd1;

  always_comb begin
    rd_word = '0;
    case (rd_kind)
      aplic_pkg::KIND_DOMAINCFG:
        rd_word = aplic_pkg::DOMAINCFG_FIXED | {23'd0, i_domain_ie[i_rd_domain], 5'd0,
                  i_domain_dm[i_rd_domain], 1'b0, i_domain_be[i_rd_domain]};
      aplic_pkg::KIND_SOURCECFG: begin
        if (own_mask[rd_idx]) rd_word = {21'd0, i_sourcecfg[rd_idx]};
        // M sees its delegated sources as D=1, child 0
        else if (i_rd_domain == aplic_pkg::DOMAIN_M) rd_word = {21'd0, 1'b1, 10'd0};
      end
      aplic_pkg::KIND_SETIP:  rd_word = i_pending & own_mask;
      aplic_pkg::KIND_SETIE:  rd_word = i_enable & own_mask;
      aplic_pkg::KIND_TARGET: if (own_mask[rd_idx]) rd_word = i_target[rd_idx];
      default:                rd_word = '0;
    endcase
  end

  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) rd_valid_q <= 1'b0;
    else rd_valid_q <= i_rd_valid;
  end

  always_ff @(posedge i_clk) begin
    rd_data_q <= rd_word;
  end

  assign o_rd_valid = rd_valid_q;
  assign o_rd_data  = rd_data_q;

endmodule

/* design/aplic_target.sv */
// APLIC target registers
// One word per source, written by its owner domain while active
// and legalized by that domain's delivery mode

`timescale 1ns/1ps

module aplic_target (
  input  logic                                i_clk,
  input  logic                                ni_rst,
  input  logic [aplic_pkg::NR_SRC-1:0]        i_active,
  input  logic [aplic_pkg::NR_SRC-1:0]        i_intp_domain,
  input  logic [1:0]                          i_domain_dm,
  output logic [aplic_pkg::NR_SRC-1:1][31:0]  o_target,
  reg_wr_if.sink                              wr
);

  logic [aplic_pkg::NR_SRC-1:1][31:0]  target_q;
  aplic_pkg::target_u                  wt;
  aplic_pkg::target_u                  nt;
  logic                                wr_ok;

  assign wt    = wr.wr_data;
  assign wr_ok = wr.wr_valid && (wr.wr_kind == aplic_pkg::KIND_TARGET) &&
                 (i_intp_domain[wr.wr_index] == wr.wr_domain) && i_active[wr.wr_index];

  always_comb begin
    nt = '0;
    if (i_domain_dm[wr.wr_domain]) begin
      // MSI delivery
      nt = wt;
      nt.msi.rsvd = 1'b0;
    end else begin
      // Direct delivery, priority 0 is not allowed
      nt.direct.hart = wt.direct.hart;
      nt.direct.prio = (wt.direct.prio == 8'd0) ? 8'd1 : wt.direct.prio;
    end
  end

  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      target_q <= '0;
    end else if (wr_ok) begin
      target_q[wr.wr_index] <= nt;
    end
  end

  assign o_target = target_q;

endmodule

/* design/cfg/aplic_source_cfg.sv */
// APLIC domaincfg and sourcecfg registers
// Keeps IE/DM/BE per domain, the legalized source modes, which
// domain owns each source and the active vector

`timescale 1ns/1ps

module aplic_source_cfg (
  input  logic                                      i_clk,
  input  logic                                      ni_rst,
  output logic [1:0]                                o_domain_ie,
  output logic [1:0]                                o_domain_dm,
  output logic [1:0]                                o_domain_be,
  output aplic_pkg::sourcecfg_u [aplic_pkg::NR_SRC-1:1] o_sourcecfg,
  output logic [aplic_pkg::NR_SRC-1:0]              o_intp_domain,
  output logic [aplic_pkg::NR_SRC-1:0]              o_active,
  reg_wr_if.sink                                    wr
);

  logic [1:0]                                        ie_q, ie_d;
  logic [1:0]                                        dm_q, dm_d;
  logic [1:0]                                        be_q, be_d;
  aplic_pkg::sourcecfg_u [aplic_pkg::NR_SRC-1:1]     cfg_q, cfg_d;
  logic [aplic_pkg::NR_SRC-1:0]                      owner_q, owner_d;
  aplic_pkg::sourcecfg_u                             wcfg;

  // Reserved mode codes 2 and 3 fall back to inactive
  function automatic logic [2:0] legal_sm(input logic [2:0] sm);
    logic [2:0] res;
    case (sm)
      aplic_pkg::SM_DETACHED, aplic_pkg::SM_EDGE1, aplic_pkg::SM_EDGE0,
      aplic_pkg::SM_LEVEL1, aplic_pkg::SM_LEVEL0: res = sm;
      default: res = aplic_pkg::SM_INACTIVE;
    endcase
    return res;
  endfunction

  assign wcfg = wr.wr_data[10:0];

  always_comb begin
    ie_d    = ie_q;
    dm_d    = dm_q;
    be_d    = be_q;
    cfg_d   = cfg_q;
    owner_d = owner_q;

    if (wr.wr_valid && wr.wr_kind == aplic_pkg::KIND_DOMAINCFG) begin
      ie_d[wr.wr_domain] = wr.wr_data[8];
      dm_d[wr.wr_domain] = wr.wr_data[2];
      be_d[wr.wr_domain] = wr.wr_data[0];
    end

    if (wr.wr_valid && wr.wr_kind == aplic_pkg::KIND_SOURCECFG) begin
      if (wr.wr_domain == aplic_pkg::DOMAIN_M) begin
        // M decides the owner on every write
        cfg_d[wr.wr_index] = '0;
        if (wcfg.deleg.d) begin
          owner_d[wr.wr_index] = aplic_pkg::DOMAIN_S;
        end else begin
          owner_d[wr.wr_index] = aplic_pkg::DOMAIN_M;
          cfg_d[wr.wr_index].mode.sm = legal_sm(wcfg.mode.sm);
        end
      end else if (owner_q[wr.wr_index] == aplic_pkg::DOMAIN_S) begin
        // S has no child domain, so D=1 leaves the source inactive
        cfg_d[wr.wr_index] = '0;
        if (!wcfg.mode.d) cfg_d[wr.wr_index].mode.sm = legal_sm(wcfg.mode.sm);
      end
    end
  end

  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      ie_q    <= '0;
      dm_q    <= '0;
      be_q    <= '0;
      cfg_q   <= '0;
      owner_q <= '0;
    end else begin
      ie_q    <= ie_d;
      dm_q    <= dm_d;
      be_q    <= be_d;
      cfg_q   <= cfg_d;
      owner_q <= owner_d;
    end
  end

  always_comb begin
    o_active = '0;
    for (int j = 1; j < aplic_pkg::NR_SRC; j++) begin
      o_active[j] = cfg_q[j].mode.sm != aplic_pkg::SM_INACTIVE;
    end
  end

  assign o_domain_ie   = ie_q;
  assign o_domain_dm   = dm_q;
  assign o_domain_be   = be_q;
  assign o_sourcecfg   = cfg_q;
  assign o_intp_domain = owner_q;

endmodule

/* design/ipie/aplic_bit_update.sv */
// APLIC set/clear resolution for one register family
// Turns a setix, clrix, setixnum or clrixnum write into the
// next word, limited to sources of the writing domain

`timescale 1ns/1ps

module aplic_bit_update #(
  parameter bit FAMILY_ENABLE = 1'b0
) (
  input  logic [aplic_pkg::NR_SRC-1:0]   i_cur,
  input  logic [aplic_pkg::NR_SRC-1:0]   i_intp_domain,
  output logic [aplic_pkg::NR_SRC-1:0]   o_next,
  reg_wr_if.sink                         wr
);

  aplic_pkg::reg_kind_e              kind_set_word;
  aplic_pkg::reg_kind_e              kind_clr_word;
  aplic_pkg::reg_kind_e              kind_set_num;
  aplic_pkg::reg_kind_e              kind_clr_num;
  logic [aplic_pkg::NR_SRC-1:0]      own_mask;
  logic [aplic_pkg::SRC_W-1:0]       num;
  logic                              num_ok;

  // Kinds served by this instance
  assign kind_set_word = FAMILY_ENABLE ? aplic_pkg::KIND_SETIE : aplic_pkg::KIND_SETIP;
  assign kind_clr_word = FAMILY_ENABLE ? aplic_pkg::KIND_CLRIE : aplic_pkg::KIND_CLRIP;
  assign kind_set_num  = FAMILY_ENABLE ? aplic_pkg::KIND_SETIENUM : aplic_pkg::KIND_SETIPNUM;
  assign kind_clr_num  = FAMILY_ENABLE ? aplic_pkg::KIND_CLRIENUM : aplic_pkg::KIND_CLRIPNUM;

  assign own_mask = (wr.wr_domain ? i_intp_domain : ~i_intp_domain) & ~32'd1;
  assign num      = wr.wr_data[aplic_pkg::SRC_W-1:0];
  // Number must name an existing source of the writer
  assign num_ok   = (wr.wr_data[31:aplic_pkg::SRC_W] == '0) && (num != '0) && own_mask[num];

  always_comb begin
    o_next = i_cur;
    if (wr.wr_valid) begin
      if (wr.wr_kind == kind_set_word) o_next = i_cur | (wr.wr_data & own_mask);
      else if (wr.wr_kind == kind_clr_word) o_next = i_cur & ~(wr.wr_data & own_mask);
      else if (wr.wr_kind == kind_set_num && num_ok) o_next[num] = 1'b1;
      else if (wr.wr_kind == kind_clr_num && num_ok) o_next[num] = 1'b0;
    end
    o_next[0] = 1'b0;
  end

endmodule

/* design/ipie/aplic_pending_enable.sv */
// APLIC pending and enable registers
// One word each; written by the owner domain, pending also set
// by the source strobe, both masked to active sources

`timescale 1ns/1ps

module aplic_pending_enable (
  input  logic                           i_clk,
  input  logic                           ni_rst,
  input  logic [aplic_pkg::NR_SRC-1:0]   i_src_set,
  input  logic [aplic_pkg::NR_SRC-1:0]   i_active,
  input  logic [aplic_pkg::NR_SRC-1:0]   i_intp_domain,
  output logic [aplic_pkg::NR_SRC-1:0]   o_pending,
  output logic [aplic_pkg::NR_SRC-1:0]   o_enable,
  reg_wr_if.sink                         wr
);

  logic [aplic_pkg::NR_SRC-1:0] pending_q, pending_upd;
  logic [aplic_pkg::NR_SRC-1:0] enable_q, enable_upd;

  aplic_bit_update #(.FAMILY_ENABLE(1'b0)) u_pending_upd (
    .i_cur         (pending_q),
    .i_intp_domain (i_intp_domain),
    .o_next        (pending_upd),
    .wr            (wr)
  );

  aplic_bit_update #(.FAMILY_ENABLE(1'b1)) u_enable_upd (
    .i_cur         (enable_q),
    .i_intp_domain (i_intp_domain),
    .o_next        (enable_upd),
    .wr            (wr)
  );

  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      pending_q <= (pending_upd | i_src_set) & i_active;
      enable_q  <= enable_upd & i_active;
    end
  end

  assign o_pending = pending_q;
  assign o_enable  = enable_q;

endmodule

/* flist.f */
+incdir+verif
common/aplic_pkg.sv
common/aplic_reg_if.sv
design/ipie/aplic_bit_update.sv
design/ipie/aplic_pending_enable.sv
design/cfg/aplic_source_cfg.sv
design/aplic_target.sv
design/aplic_reg_decode.sv
design/aplic_domain_top.sv
verif/tb_aplic_domain.sv

/* run.sh */
#!/bin/sh
# Build the APLIC domain testbench with Verilator, run it and
# look for the pass line in its output
cd "$(dirname "$0")" && \
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f flist.f --top-module tb_aplic_domain -o tb_aplic_domain && \
./obj_dir/tb_aplic_domain | tee /dev/stderr | grep -q "test passed" && \
echo "run.sh: simulation ok" || { echo "run.sh: simulation failed"; exit 1; }

/* verif/tb_aplic_table.svh */
// APLIC domain testbench table
// Record type, op codes and the register access sequence
// used by the table loop

`ifndef TB_APLIC_TABLE_SVH
`define TB_APLIC_TABLE_SVH

// Each entry holds test, op, domain, offset or output select, write data and expected value
typedef struct {
  int          test;
  logic [1:0]  kind;
  logic        dom;
  logic [13:0] addr;
  logic [31:0] data;
  logic [31:0] exp;
} table_op_t;

localparam logic [1:0] OP_WR  = 2'd0;
localparam logic [1:0] OP_RD  = 2'd1;
localparam logic [1:0] OP_CHK = 2'd2;

localparam logic DOM_M = 1'b0;
localparam logic DOM_S = 1'b1;

// Output selects for OP_CHK entries
localparam logic [13:0] SEL_ACTIVE  = 14'd0;
localparam logic [13:0] SEL_PENDING = 14'd1;
localparam logic [13:0] SEL_ENABLE  = 14'd2;
localparam logic [13:0] SEL_OWNER   = 14'd3;
localparam logic [13:0] SEL_DOMCFG  = 14'd4;
localparam logic [13:0] SEL_ANY     = 14'd5;

// Active sources once test 2 has run (2, 3, 5 and 6)
localparam logic [31:0] RAND_ACTIVE = 32'h0000_006C;

table_op_t ops[$];

task automatic push_op(input int t, input logic [1:0] k, input logic d,
                       input logic [13:0] a, input logic [31:0] wd, input logic [31:0] e);
  table_op_t op;
  op.test = t;
  op.kind = k;
  op.dom  = d;
  op.addr = a;
  op.data = wd;
  op.exp  = e;
  ops.push_back(op);
endtask

task automatic load_table();
  // ==========================================================
  // 1: reset values
  // ==========================================================
  push_op(1, OP_CHK, DOM_M, SEL_ANY,  32'h0,         32'h0);
  push_op(1, OP_RD,  DOM_M, 14'h0000, 32'h0,         32'h8000_0000);
  push_op(1, OP_RD,  DOM_S, 14'h0000, 32'h0,         32'h8000_0000);
  push_op(1, OP_RD,  DOM_M, 14'h000C, 32'h0,         32'h0);
  push_op(1, OP_RD,  DOM_M, 14'h300C, 32'h0,         32'h0);
  push_op(1, OP_RD,  DOM_M, 14'h1C00, 32'h0,         32'h0);
  push_op(1, OP_RD,  DOM_M, 14'h1E00, 32'h0,         32'h0);
  // ==========================================================
  // 2: domaincfg and sourcecfg
  // ==========================================================
  push_op(2, OP_WR,  DOM_M, 14'h0000, 32'hFFFF_FFFF, 32'h0);
  push_op(2, OP_RD,  DOM_M, 14'h0000, 32'h0,         32'h8000_0105);
  push_op(2, OP_CHK, DOM_M, SEL_DOMCFG, 32'h0,       32'h0000_0005);
  push_op(2, OP_WR,  DOM_M, 14'h0000, 32'h0000_0100, 32'h0);
  push_op(2, OP_CHK, DOM_M, SEL_DOMCFG, 32'h0,       32'h0000_0001);
  // Source 2 delegated to S
  push_op(2, OP_WR,  DOM_M, 14'h0008, 32'h0000_0400, 32'h0);
  push_op(2, OP_CHK, DOM_M, SEL_OWNER, 32'h0,        32'h0000_0004);
  push_op(2, OP_RD,  DOM_M, 14'h0008, 32'h0,         32'h0000_0400);
  push_op(2, OP_WR,  DOM_S, 14'h0008, 32'h0000_0006, 32'h0);
  push_op(2, OP_RD,  DOM_S, 14'h0008, 32'h0,         32'h0000_0006);
  // Illegal SM, then a foreign write
  push_op(2, OP_WR,  DOM_M, 14'h000C, 32'h0000_0002, 32'h0);
  push_op(2, OP_RD,  DOM_M, 14'h000C, 32'h0,         32'h0);
  push_op(2, OP_WR,  DOM_M, 14'h000C, 32'h0000_0004, 32'h0);
  push_op(2, OP_WR,  DOM_S, 14'h000C, 32'h0000_0005, 32'h0);
  push_op(2, OP_RD,  DOM_M, 14'h000C, 32'h0,         32'h0000_0004);
  push_op(2, OP_WR,  DOM_M, 14'h0014, 32'h0000_0400, 32'h0);
  push_op(2, OP_WR,  DOM_S, 14'h0014, 32'h0000_0005, 32'h0);
  push_op(2, OP_WR,  DOM_M, 14'h0018, 32'h0000_0006, 32'h0);
  push_op(2, OP_CHK, DOM_M, SEL_ACTIVE, 32'h0,       RAND_ACTIVE);
  // ==========================================================
  // 3: enable family
  // ==========================================================
  push_op(3, OP_WR,  DOM_M, 14'h1E00, 32'hFFFF_FFFF, 32'h0);
  push_op(3, OP_RD,  DOM_M, 14'h1E00, 32'h0,         32'h0000_0048);
  push_op(3, OP_WR,  DOM_S, 14'h1EDC, 32'h0000_0002, 32'h0);
  push_op(3, OP_WR,  DOM_S, 14'h1EDC, 32'h0000_0000, 32'h0);
  push_op(3, OP_WR,  DOM_M, 14'h1EDC, 32'h0000_0007, 32'h0);
  push_op(3, OP_CHK, DOM_M, SEL_ENABLE, 32'h0,       32'h0000_004C);
  push_op(3, OP_WR,  DOM_S, 14'h1F00, 32'hFFFF_FFFF, 32'h0);
  push_op(3, OP_WR,  DOM_M, 14'h1FDC, 32'h0000_0003, 32'h0);
  // Source 3 is clear again, so a foreign set would show
  push_op(3, OP_WR,  DOM_S, 14'h1EDC, 32'h0000_0003, 32'h0);
  push_op(3, OP_RD,  DOM_M, 14'h1E00, 32'h0,         32'h0000_0040);
  push_op(3, OP_RD,  DOM_S, 14'h1E00, 32'h0,         32'h0);
  // ==========================================================
  // 4: pending family
  // ==========================================================
  push_op(4, OP_WR,  DOM_M, 14'h1CDC, 32'h0000_0003, 32'h0);
  push_op(4, OP_WR,  DOM_M, 14'h1CDC, 32'h0000_0002, 32'h0);
  push_op(4, OP_WR,  DOM_S, 14'h1CDC, 32'h0000_0005, 32'h0);
  push_op(4, OP_WR,  DOM_M, 14'h1CDC, 32'h0000_0026, 32'h0);
  push_op(4, OP_RD,  DOM_S, 14'h1C00, 32'h0,         32'h0000_0020);
  push_op(4, OP_CHK, DOM_M, SEL_PENDING, 32'h0,      32'h0000_0028);
  push_op(4, OP_WR,  DOM_M, 14'h1C00, 32'hFFFF_FFFF, 32'h0);
  push_op(4, OP_WR,  DOM_S, 14'h1D00, 32'hFFFF_FFFF, 32'h0);
  push_op(4, OP_RD,  DOM_M, 14'h1D00, 32'h0,         32'h0);
  push_op(4, OP_WR,  DOM_M, 14'h1DDC, 32'h0000_0006, 32'h0);
  push_op(4, OP_CHK, DOM_M, SEL_PENDING, 32'h0,      32'h0000_0008);
  push_op(4, OP_WR,  DOM_M, 14'h1D00, 32'hFFFF_FFFF, 32'h0);
  push_op(4, OP_CHK, DOM_M, SEL_PENDING, 32'h0,      32'h0);
  // ==========================================================
  // 5: target legalization
  // ==========================================================
  push_op(5, OP_WR,  DOM_M, 14'h300C, 32'h1234_5600, 32'h0);
  push_op(5, OP_RD,  DOM_M, 14'h300C, 32'h0,         32'h1234_0001);
  push_op(5, OP_WR,  DOM_S, 14'h300C, 32'h0000_0005, 32'h0);
  push_op(5, OP_RD,  DOM_M, 14'h300C, 32'h0,         32'h1234_0001);
  push_op(5, OP_WR,  DOM_M, 14'h301C, 32'h0000_0055, 32'h0);
  push_op(5, OP_RD,  DOM_M, 14'h301C, 32'h0,         32'h0);
  push_op(5, OP_WR,  DOM_M, 14'h0000, 32'h0000_0104, 32'h0);
  push_op(5, OP_WR,  DOM_M, 14'h300C, 32'h0004_0ABC, 32'h0);
  push_op(5, OP_RD,  DOM_M, 14'h300C, 32'h0,         32'h0004_02BC);
  push_op(5, OP_WR,  DOM_M, 14'h3018, 32'hFFFF_FFFF, 32'h0);
  push_op(5, OP_RD,  DOM_M, 14'h3018, 32'h0,         32'hFFFF_F7FF);
  push_op(5, OP_WR,  DOM_S, 14'h3014, 32'h0000_1F00, 32'h0);
  push_op(5, OP_RD,  DOM_S, 14'h3014, 32'h0,         32'h0000_0001);
  push_op(5, OP_CHK, DOM_M, SEL_DOMCFG, 32'h0,       32'h0000_0005);
endtask

`endif

/* verif/tb_aplic_domain.sv */
// Testbench for the APLIC domain register control
// Runs the register table test by test, then a random
// source strobe phase against a model of the pending word

`timescale 1ns/1ps

module tb_aplic_domain;

  localparam int RD_TIMEOUT  = 8;
  localparam int MAX_CYCLES  = 3000;
  localparam int RAND_CYCLES = 40;

  logic        i_clk;
  logic        ni_rst;
  logic        i_wr_valid;
  logic        i_wr_domain;
  logic [13:0] i_wr_addr;
  logic [31:0] i_wr_data;
  logic        i_rd_valid;
  logic        i_rd_domain;
  logic [13:0] i_rd_addr;
  logic        o_rd_valid;
  logic [31:0] o_rd_data;
  logic [31:0] i_src_set;
  logic [31:0] o_active;
  logic [31:0] o_pending;
  logic [31:0] o_enable;
  logic [31:0] o_intp_domain;
  logic [1:0]  o_domain_ie;
  logic [1:0]  o_domain_dm;

  int          checks;
  int          errors;
  int          test_errors;

  `include "tb_aplic_table.svh"

  aplic_domain_top dut (
    .i_clk         (i_clk),
    .ni_rst        (ni_rst),
    .i_wr_valid    (i_wr_valid),
    .i_wr_domain   (i_wr_domain),
    .i_wr_addr     (i_wr_addr),
    .i_wr_data     (i_wr_data),
    .i_rd_valid    (i_rd_valid),
    .i_rd_domain   (i_rd_domain),
    .i_rd_addr     (i_rd_addr),
    .o_rd_valid    (o_rd_valid),
    .o_rd_data     (o_rd_data),
    .i_src_set     (i_src_set),
    .o_active      (o_active),
    .o_pending     (o_pending),
    .o_enable      (o_enable),
    .o_intp_domain (o_intp_domain),
    .o_domain_ie   (o_domain_ie),
    .o_domain_dm   (o_domain_dm)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  // Watchdog for the whole run
  initial begin
    repeat (MAX_CYCLES) @(posedge i_clk);
    $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("test failed");
    $finish;
  end

  function automatic string test_name(input int t);
    case (t)
      1:       return "reset values";
      2:       return "domaincfg and sourcecfg";
      3:       return "enable family";
      4:       return "pending family";
      default: return "target legalization";
    endcase
  endfunction

  function automatic logic [31:0] output_word(input logic [13:0] sel);
    case (sel)
      SEL_ACTIVE:  return o_active;
      SEL_PENDING: return o_pending;
      SEL_ENABLE:  return o_enable;
      SEL_OWNER:   return o_intp_domain;
      SEL_DOMCFG:  return {28'd0, o_domain_dm, o_domain_ie};
      default:     return o_active | o_pending | o_enable | o_intp_domain |
                          {27'd0, o_rd_valid, o_domain_dm, o_domain_ie};
    endcase
  endfunction

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s gave 0x%08h, expected 0x%08h", $time, what, got, exp);
      test_errors++;
    end
  endtask

  // Drive one table entry for a cycle, then sample at the falling edge
  task automatic apply_op(input table_op_t op);
    int waited;
    @(posedge i_clk);
    if (op.kind == OP_WR) begin
      i_wr_valid  <= 1'b1;
      i_wr_domain <= op.dom;
      i_wr_addr   <= op.addr;
      i_wr_data   <= op.data;
    end else if (op.kind == OP_RD) begin
      i_rd_valid  <= 1'b1;
      i_rd_domain <= op.dom;
      i_rd_addr   <= op.addr;
    end
    @(posedge i_clk);
    i_wr_valid <= 1'b0;
    i_rd_valid <= 1'b0;
    @(negedge i_clk);
    if (op.kind == OP_RD) begin
      waited = 0;
      while (!o_rd_valid && waited < RD_TIMEOUT) begin
        @(negedge i_clk);
        waited++;
      end
      if (!o_rd_valid) begin
        $display("Timeout: no read response for offset 0x%04h", op.addr);
        test_errors++;
      end else begin
        check_word($sformatf("read domain %0d offset 0x%04h", op.dom, op.addr),
                   o_rd_data, op.exp);
      end
    end else if (op.kind == OP_CHK) begin
      check_word($sformatf("output select %0d", op.addr), output_word(op.addr), op.exp);
    end
  endtask

  // Strobe taken at the next edge, masked to active sources
  task automatic random_pending_phase();
    logic [31:0] strobe;
    logic [31:0] model;
    model  = '0;
    strobe = $urandom;
    @(posedge i_clk);
    i_src_set <= strobe;
    for (int n = 0; n < RAND_CYCLES; n++) begin
      @(posedge i_clk);
      model  = (model | strobe) & RAND_ACTIVE;
      strobe = $urandom;
      i_src_set <= strobe;
      @(negedge i_clk);
      check_word("pending after source strobe", o_pending, model);
    end
    @(posedge i_clk);
    i_src_set <= '0;
  endtask

  task automatic run_test(input int t);
    test_errors = 0;
    foreach (ops[i]) begin
      if (ops[i].test == t) apply_op(ops[i]);
    end
    if (t == 4) random_pending_phase();
    $display("Test %0d (%s): %s, %0d errors", t, test_name(t),
             (test_errors == 0) ? "ok" : "bad", test_errors);
    errors += test_errors;
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    void'($urandom(71823));
    checks       = 0;
    errors       = 0;
    test_errors  = 0;
    ni_rst       = 1'b0;
    i_wr_valid   = 1'b0;
    i_wr_domain  = 1'b0;
    i_wr_addr    = '0;
    i_wr_data    = '0;
    i_rd_valid   = 1'b0;
    i_rd_domain  = 1'b0;
    i_rd_addr    = '0;
    i_src_set    = '0;
    load_table();

    repeat (16) @(posedge i_clk);
    ni_rst <= 1'b1;

    for (int t = 1; t <= 5; t++) begin
      run_test(t);
    end

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
